// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Register file index width, x0..x31
    localparam int unsigned reg_idx_w = 5;

    // Fixed RV32I instruction size in bytes, used for the link address
    localparam int unsigned inst_bytes = 4;

    // ALU function codes
    // Low three bits follow funct3, bit 3 marks the funct7 alternate form
    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_sll    = 4'b0001,
        alu_slt    = 4'b0010,
        alu_sltu   = 4'b0011,
        alu_xor    = 4'b0100,
        alu_srl    = 4'b0101,
        alu_or     = 4'b0110,
        alu_and    = 4'b0111,
        alu_sub    = 4'b1000,  // funct7 bit 5 set
        alu_sra    = 4'b1101,  // funct7 bit 5 set
        alu_pass_b = 4'b1111   // Operand b straight through
    } alu_fn_t;

    // Branch conditions, encoded as the B-type funct3
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } br_cond_t;

endpackage

`default_nettype wire

// File: source/ex_ctrl_pkg.sv
`default_nettype none

package ex_ctrl_pkg;

    // Operand class from decode, picks where ALU operands come from
    typedef enum logic [2:0] {
        op_mem    = 3'b000,  // Load or store, address is rs1 + imm
        op_branch = 3'b001,  // Conditional branch
        op_arith  = 3'b010,  // R-type or I-type arithmetic
        op_jal    = 3'b011,
        op_lui    = 3'b100,
        op_auipc  = 3'b101,
        op_jalr   = 3'b111
    } op_class_t;

    // Classes that write a destination register
    // Mem and branch never do in this stage
    function automatic logic class_writes_rd(op_class_t cls);
        return !(cls inside {op_mem, op_branch});
    endfunction

endpackage

`default_nettype wire

// File: source/operand_select.sv
`default_nettype none

module operand_select #(
    parameter int unsigned xlen = 32
) (
    input  ex_ctrl_pkg::op_class_t op_class,
    input  rv_isa_pkg::alu_fn_t    alu_fn,
    input  logic                   imm_sel,     // 1 selects imm as operand b
    input  logic [xlen-1:0]        rs1_value,
    input  logic [xlen-1:0]        rs2_value,
    input  logic [xlen-1:0]        imm,
    input  logic [xlen-1:0]        pc,
    output logic [xlen-1:0]        op_a,
    output logic [xlen-1:0]        op_b,
    output rv_isa_pkg::alu_fn_t    alu_fn_eff   // Function the ALU actually runs
);
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;

    // Link offset, pc + 4 is the return address
    localparam logic [xlen-1:0] link_step = xlen'(inst_bytes);

    always_comb
    begin
        // Defaults match register arithmetic
        op_a       = rs1_value;
        op_b       = rs2_value;
        alu_fn_eff = alu_fn;
        case (op_class)
            op_mem:
            begin
                op_b       = imm;      // Effective address
                alu_fn_eff = alu_add;
            end
            op_branch:
            begin
                // Result is dropped, branch_unit makes the decision
                alu_fn_eff = alu_sub;
            end
            op_arith:
            begin
                op_b = imm_sel ? imm : rs2_value;
            end
            op_lui:
            begin
                op_a       = '0;       // 0 + imm gives the upper immediate
                op_b       = imm;
                alu_fn_eff = alu_add;
            end
            op_auipc:
            begin
                op_a       = pc;
                op_b       = imm;
                alu_fn_eff = alu_add;
            end
            op_jal, op_jalr:
            begin
                op_a       = pc;
                op_b       = link_step;
                alu_fn_eff = alu_add;  // Link address into rd
            end
            default: ;                 // Unused class code, keep defaults
        endcase
    end

endmodule

`default_nettype wire

// File: source/alu.sv
`default_nettype none

module alu #(
    parameter int unsigned xlen = 32
) (
    input  rv_isa_pkg::alu_fn_t fn,
    input  logic                check_en,  // Instruction in the stage is valid
    input  logic [xlen-1:0]     a,
    input  logic [xlen-1:0]     b,
    output logic [xlen-1:0]     y
);
    import rv_isa_pkg::*;

    // 5 bits at 32, 6 bits at 64
    localparam int unsigned shamt_w = $clog2(xlen);

    logic [shamt_w-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = b[shamt_w-1:0];  // Upper bits of b ignored, as in RV32I
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (fn)
            alu_add:    y = a + b;
            alu_sub:    y = a - b;
            alu_sll:    y = a << shamt;
            alu_slt:    y = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   y = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:    y = a ^ b;
            alu_srl:    y = a >> shamt;
            alu_sra:    y = $unsigned($signed(a) >>> shamt);  // Sign fills from the left
            alu_or:     y = a | b;
            alu_and:    y = a & b;
            alu_pass_b: y = b;
            default:    y = '0;  // Unassigned codes
        endcase
    end

    // Decode must hand over a known function whenever the slot is live
    always_comb
    begin
        if (check_en)
        begin
            assert final (!$isunknown(fn))
                else $error("alu: function code unknown with valid instruction");
        end
    end

endmodule

`default_nettype wire

// File: source/branch_unit.sv
`default_nettype none

module branch_unit #(
    parameter int unsigned xlen = 32
) (
    input  ex_ctrl_pkg::op_class_t op_class,
    input  rv_isa_pkg::br_cond_t   br_cond,
    input  logic [xlen-1:0]        rs1_value,
    input  logic [xlen-1:0]        rs2_value,
    input  logic [xlen-1:0]        pc,
    input  logic [xlen-1:0]        imm,
    output logic                   taken,
    output logic [xlen-1:0]        target
);
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            cond_met;
    logic [xlen-1:0] pc_rel;     // pc + imm for branch and jal
    logic [xlen-1:0] reg_rel;    // rs1 + imm for jalr

    assign eq      = rs1_value == rs2_value;
    assign lt_s    = $signed(rs1_value) < $signed(rs2_value);
    assign lt_u    = rs1_value < rs2_value;
    assign pc_rel  = pc + imm;
    assign reg_rel = rs1_value + imm;

    always_comb
    begin
        case (br_cond)
            br_beq:  cond_met = eq;
            br_bne:  cond_met = !eq;
            br_blt:  cond_met = lt_s;
            br_bge:  cond_met = !lt_s;
            br_bltu: cond_met = lt_u;
            br_bgeu: cond_met = !lt_u;
            default: cond_met = 1'b0;  // funct3 010 and 011 are not branches
        endcase
    end

    always_comb
    begin
        taken  = 1'b0;
        target = pc_rel;
        case (op_class)
            op_branch: taken = cond_met;
            op_jal:    taken = 1'b1;
            op_jalr:
            begin
                taken  = 1'b1;
                target = {reg_rel[xlen-1:1], 1'b0};  // LSB dropped per spec
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/ex_mem_register.sv
`default_nettype none

module ex_mem_register #(
    parameter int unsigned xlen = 32
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               stall,      // Hold everything
    input  logic                               flush,      // Drop the held instruction
    input  logic                               in_valid,
    input  ex_ctrl_pkg::op_class_t             op_class,
    input  logic [xlen-1:0]                    alu_result,
    input  logic [xlen-1:0]                    target,
    input  logic [xlen-1:0]                    rs2_value,
    input  logic                               taken,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]   rd,
    output logic                               out_valid,
    output logic [rv_isa_pkg::reg_idx_w-1:0]   out_rd,
    output logic                               rd_we,
    output logic                               branch_taken,
    output logic [xlen-1:0]                    result,
    output logic [xlen-1:0]                    branch_target,
    output logic [xlen-1:0]                    store_data
);
    import ex_ctrl_pkg::*;

    logic rd_we_next;

    // x0 writes are discarded here so later stages need not check
    assign rd_we_next = in_valid && class_writes_rd(op_class) && (rd != '0);

    // Control bits, flush wins over stall
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_valid    <= 1'b0;
            rd_we        <= 1'b0;
            branch_taken <= 1'b0;
        end
        else if (flush)
        begin
            out_valid    <= 1'b0;
            rd_we        <= 1'b0;
            branch_taken <= 1'b0;
        end
        else if (!stall)
        begin
            out_valid    <= in_valid;
            rd_we        <= rd_we_next;
            branch_taken <= in_valid && taken;  // Bubbles never redirect
        end
    end

    // Data side, only qualified by the control bits above
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            result        <= alu_result;
            branch_target <= target;
            store_data    <= rs2_value;
            out_rd        <= rd;
        end
    end

    a_flush_clears: assert property (@(posedge clk) disable iff (rst)
        flush |=> !out_valid && !rd_we && !branch_taken)
        else $error("ex_mem_register: state survived a flush");

    // Held instruction must not change under stall
    a_stall_holds: assert property (@(posedge clk) disable iff (rst)
        stall && !flush && out_valid |=> $stable(out_valid) && $stable(rd_we)
            && $stable(branch_taken) && $stable(result) && $stable(branch_target)
            && $stable(store_data) && $stable(out_rd))
        else $error("ex_mem_register: outputs moved during stall");

endmodule

`default_nettype wire

// File: source/execute_top.sv
`default_nettype none

module execute_top #(
    parameter int unsigned xlen = 32
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    input  ex_ctrl_pkg::op_class_t             op_class,
    input  rv_isa_pkg::alu_fn_t                alu_fn,
    input  rv_isa_pkg::br_cond_t               br_cond,
    input  logic                               imm_sel,
    input  logic [xlen-1:0]                    rs1_value,
    input  logic [xlen-1:0]                    rs2_value,
    input  logic [xlen-1:0]                    imm,
    input  logic [xlen-1:0]                    pc,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]   rd,
    input  logic                               stall,
    input  logic                               flush,
    output logic                               out_valid,
    output logic [xlen-1:0]                    result,
    output logic [rv_isa_pkg::reg_idx_w-1:0]   out_rd,
    output logic                               rd_we,
    output logic                               branch_taken,
    output logic [xlen-1:0]                    branch_target,
    output logic [xlen-1:0]                    store_data   // rs2 for the memory stage
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    alu_fn_t         alu_fn_eff;
    logic [xlen-1:0] alu_result;
    logic            taken;
    logic [xlen-1:0] target;

    operand_select #(.xlen(xlen)) u_operand_select (
        .op_class   (op_class),
        .alu_fn     (alu_fn),
        .imm_sel    (imm_sel),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .imm        (imm),
        .pc         (pc),
        .op_a       (op_a),
        .op_b       (op_b),
        .alu_fn_eff (alu_fn_eff)
    );

    alu #(.xlen(xlen)) u_alu (
        .fn       (alu_fn_eff),
        .check_en (in_valid),   // Only live slots are checked
        .a        (op_a),
        .b        (op_b),
        .y        (alu_result)
    );

    branch_unit #(.xlen(xlen)) u_branch_unit (
        .op_class  (op_class),
        .br_cond   (br_cond),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .pc        (pc),
        .imm       (imm),
        .taken     (taken),
        .target    (target)
    );

    // Single stage of storage, the only cycle of latency
    ex_mem_register #(.xlen(xlen)) u_ex_mem_register (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .flush         (flush),
        .in_valid      (in_valid),
        .op_class      (op_class),
        .alu_result    (alu_result),
        .target        (target),
        .rs2_value     (rs2_value),
        .taken         (taken),
        .rd            (rd),
        .out_valid     (out_valid),
        .out_rd        (out_rd),
        .rd_we         (rd_we),
        .branch_taken  (branch_taken),
        .result        (result),
        .branch_target (branch_target),
        .store_data    (store_data)
    );

endmodule

`default_nettype wire

// File: testbench/tb_execute_top.sv
`default_nettype none

module tb_execute_top;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;

    localparam int unsigned xlen     = 32;
    localparam int          n_random = 300;
    localparam int          planned  = n_random + 44 + 30;  // Random, directed arith, reset/stall/tail
    localparam int          limit    = planned * 3 / 2;

    logic clk = 1'b0;
    logic rst;
    logic in_valid, imm_sel, stall, flush;
    op_class_t op_class;
    alu_fn_t alu_fn;
    br_cond_t br_cond;
    logic [xlen-1:0] rs1_value, rs2_value, imm, pc;
    logic [reg_idx_w-1:0] rd;
    logic out_valid, rd_we, branch_taken;
    logic [xlen-1:0] result, branch_target, store_data;
    logic [reg_idx_w-1:0] out_rd;

    // Expected EX/MEM contents
    logic exp_valid, exp_we, exp_taken, exp_chk_result, exp_chk_target;
    logic [xlen-1:0] exp_result, exp_target, exp_store;
    logic [reg_idx_w-1:0] exp_rd;
    int value_errs = 0;
    int other_errs = 0;
    int checked = 0;
    int cycle_cnt = 0;
    logic [31:0] lcg_state = 32'd51;

    const op_class_t class_list[7] = '{op_mem, op_branch, op_arith, op_lui, op_auipc, op_jal, op_jalr};
    const alu_fn_t fn_list[11] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
                                   alu_srl, alu_sra, alu_or, alu_and, alu_pass_b};
    const br_cond_t cond_list[6] = '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};

    execute_top #(.xlen(xlen)) uut (.*);

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Signed compare by flipping the sign bits, then unsigned
    function automatic logic signed_lt(logic [xlen-1:0] a, logic [xlen-1:0] b);
        return (a ^ {1'b1, {(xlen-1){1'b0}}}) < (b ^ {1'b1, {(xlen-1){1'b0}}});
    endfunction

    function automatic logic [xlen-1:0] ref_alu(alu_fn_t fn, logic [xlen-1:0] a, logic [xlen-1:0] b);
        logic [$clog2(xlen)-1:0] sh;
        logic [xlen-1:0] fill;
        sh   = b[$clog2(xlen)-1:0];
        fill = a[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0;  // Sign bits shifted in by sra
        case (fn)
            alu_add:    return a + b;
            alu_sub:    return a - b;
            alu_sll:    return a << sh;
            alu_slt:    return xlen'(signed_lt(a, b));
            alu_sltu:   return xlen'(a < b);
            alu_xor:    return a ^ b;
            alu_srl:    return a >> sh;
            alu_sra:    return (a >> sh) | fill;
            alu_or:     return a | b;
            alu_and:    return a & b;
            alu_pass_b: return b;
            default:    return '0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] ref_result(op_class_t cls, alu_fn_t fn, logic isel,
        logic [xlen-1:0] a, logic [xlen-1:0] b, logic [xlen-1:0] im, logic [xlen-1:0] p);
        case (cls)
            op_mem:          return a + im;
            op_arith:        return ref_alu(fn, a, isel ? im : b);
            op_lui:          return im;
            op_auipc:        return p + im;
            op_jal, op_jalr: return p + 4;  // Link address
            default:         return '0;     // Branch result not checked
        endcase
    endfunction

    function automatic logic [xlen-1:0] ref_target(op_class_t cls, logic [xlen-1:0] a,
        logic [xlen-1:0] im, logic [xlen-1:0] p);
        logic [xlen-1:0] sum;
        sum = a + im;
        return (cls == op_jalr) ? {sum[xlen-1:1], 1'b0} : p + im;
    endfunction

    function automatic logic ref_taken(op_class_t cls, br_cond_t cond, logic [xlen-1:0] a,
        logic [xlen-1:0] b);
        if (cls == op_jal || cls == op_jalr)
            return 1'b1;
        if (cls != op_branch)
            return 1'b0;
        case (cond)
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return signed_lt(a, b);
            br_bge:  return !signed_lt(a, b);
            br_bltu: return a < b;
            br_bgeu: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Model register, same update rules as the EX/MEM stage
    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            exp_valid <= 1'b0;
            exp_we    <= 1'b0;
            exp_taken <= 1'b0;
        end
        else if (flush)
        begin
            exp_valid <= 1'b0;
            exp_we    <= 1'b0;
            exp_taken <= 1'b0;
        end
        else if (!stall)
        begin
            exp_valid <= in_valid;
            exp_we    <= in_valid && !(op_class inside {op_mem, op_branch}) && rd != '0;
            exp_taken <= in_valid && ref_taken(op_class, br_cond, rs1_value, rs2_value);
        end
    end

    always @(posedge clk)
    begin
        if (!stall)  // Data only holds under stall
        begin
            exp_result     <= ref_result(op_class, alu_fn, imm_sel, rs1_value, rs2_value, imm, pc);
            exp_target     <= ref_target(op_class, rs1_value, imm, pc);
            exp_store      <= rs2_value;
            exp_rd         <= rd;
            exp_chk_result <= op_class != op_branch;
            exp_chk_target <= op_class inside {op_branch, op_jal, op_jalr};
        end
        if (!rst && exp_valid)
            checked <= checked + 1;
    end

    task automatic report_mismatch(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
        value_errs++;
        $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
    endtask

    task automatic report_failure(string msg);
        other_errs++;
        $display("%s", msg);
    endtask

    a_valid: assert property (@(posedge clk) disable iff (rst) out_valid == exp_valid)
        else report_mismatch("out_valid", $sampled(out_valid), $sampled(exp_valid));
    a_we: assert property (@(posedge clk) disable iff (rst) rd_we == exp_we)
        else report_mismatch("rd_we", $sampled(rd_we), $sampled(exp_we));
    a_taken: assert property (@(posedge clk) disable iff (rst) branch_taken == exp_taken)
        else report_mismatch("branch_taken", $sampled(branch_taken), $sampled(exp_taken));
    a_result: assert property (@(posedge clk) disable iff (rst)
        exp_valid && exp_chk_result |-> result == exp_result)
        else report_mismatch("result", $sampled(result), $sampled(exp_result));
    a_target: assert property (@(posedge clk) disable iff (rst)
        exp_valid && exp_chk_target |-> branch_target == exp_target)
        else report_mismatch("branch_target", $sampled(branch_target), $sampled(exp_target));
    a_store: assert property (@(posedge clk) disable iff (rst) exp_valid |-> store_data == exp_store)
        else report_mismatch("store_data", $sampled(store_data), $sampled(exp_store));
    a_rd: assert property (@(posedge clk) disable iff (rst) exp_valid |-> out_rd == exp_rd)
        else report_mismatch("out_rd", xlen'($sampled(out_rd)), xlen'($sampled(exp_rd)));
    a_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> !out_valid && !rd_we && !branch_taken)
        else report_failure("flush did not clear out_valid, rd_we and branch_taken");
    a_reset: assert property (@(posedge clk) $fell(rst) |-> !out_valid && !rd_we && !branch_taken)
        else report_failure("control outputs were not low after reset");

    task automatic drive(logic vld, op_class_t cls, alu_fn_t fn, br_cond_t cond, logic isel,
        logic [xlen-1:0] a, logic [xlen-1:0] b, logic [xlen-1:0] im, logic [xlen-1:0] p,
        logic [reg_idx_w-1:0] dst, logic stl, logic fl);
        @(posedge clk);
        in_valid  <= vld;
        op_class  <= cls;
        alu_fn    <= fn;
        br_cond   <= cond;
        imm_sel   <= isel;
        rs1_value <= a;
        rs2_value <= b;
        imm       <= im;
        pc        <= p;
        rd        <= dst;
        stall     <= stl;
        flush     <= fl;
    endtask

    task automatic drive_random(logic stl, logic fl);
        logic [31:0] sel;
        logic [31:0] ctl;
        logic [xlen-1:0] a;
        logic [xlen-1:0] p;
        sel = rand_word();
        ctl = rand_word();
        a   = rand_word();
        p   = rand_word() & ~32'd3;  // Word aligned pc
        drive(ctl[31:29] != 0, class_list[sel[31:28] % 7], fn_list[sel[27:24] % 11],
            cond_list[sel[23:20] % 6], ctl[21], a, ctl[15] ? a : rand_word(), rand_word(), p,
            ctl[20:16], stl || ctl[28:26] == 0, fl || ctl[25:22] == 0);
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= limit)
        begin
            report_failure("timeout, run did not finish within the cycle limit");
            $display("value errors %0d, other errors %0d", value_errs, other_errs);
            $display("** FAIL **");
            $finish;
        end
    end

    initial
    begin
        rst       <= 1'b1;
        in_valid  <= 1'b0;
        op_class  <= op_mem;
        alu_fn    <= alu_add;
        br_cond   <= br_beq;
        imm_sel   <= 1'b0;
        rs1_value <= '0;
        rs2_value <= '0;
        imm       <= '0;
        pc        <= '0;
        rd        <= '0;
        stall     <= 1'b0;
        flush     <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Sign boundary for slt/sltu, negative operand for sra
        foreach (fn_list[i])
        begin
            for (int isel = 0; isel < 2; isel++)
            begin
                drive(1'b1, op_arith, fn_list[i], br_beq, isel[0], 32'h8000_0000, 32'h1,
                    32'h7fff_ffff, 32'h100, 5'd3, 1'b0, 1'b0);
                drive(1'b1, op_arith, fn_list[i], br_beq, isel[0], 32'hffff_f00f, 32'h4,
                    32'hffff_ffe3, 32'h104, 5'd0, 1'b0, 1'b0);  // rd x0, no write
            end
        end
        for (int n = 0; n < n_random; n++)
            drive_random(1'b0, 1'b0);
        // Long stall, then flush during the stall
        drive(1'b1, op_jal, alu_add, br_beq, 1'b0, 32'h10, 32'h20, 32'h40, 32'h200, 5'd1,
            1'b0, 1'b0);
        repeat (4)
            drive_random(1'b1, 1'b0);
        drive_random(1'b1, 1'b1);
        repeat (4)
            drive(1'b0, op_mem, alu_add, br_beq, 1'b0, '0, '0, '0, '0, '0, 1'b0, 1'b0);
        @(posedge clk);
        if (checked == 0)
            report_failure("no instruction reached the EX/MEM outputs");
        $display("value errors %0d, other errors %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
source/rv_isa_pkg.sv
source/ex_ctrl_pkg.sv
source/operand_select.sv
source/alu.sv
source/branch_unit.sv
source/ex_mem_register.sv
source/execute_top.sv
testbench/tb_execute_top.sv

// File: Bender.yml
package:
  name: rv_execute_stage

sources:
  - source/rv_isa_pkg.sv
  - source/ex_ctrl_pkg.sv
  - source/operand_select.sv
  - source/alu.sv
  - source/branch_unit.sv
  - source/ex_mem_register.sv
  - source/execute_top.sv
  - target: test
    files:
      - testbench/tb_execute_top.sv
